// ==== build.f ====
verilog/isaPkg.sv
verilog/ctrlPkg.sv
verilog/instrDecode.sv
verilog/regFile.sv
verilog/execUnit.sv
verilog/fetchUnit.sv
verilog/dataMem.sv
verilog/wiscCore.sv
testbench/wiscCore_assert.sv
testbench/tb_wiscCore.sv

// ==== testbench/tb_wiscCore.sv ====
// Core testbench
module tb_wiscCore import isaPkg::*, ctrlPkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int dmemAddrBits = 8;
	localparam int imemWords = 256;
	// Cycle limit for one program
	localparam int runLimit = 200;
	// Cycles watched after halt
	localparam int settleCycles = 3;

	logic clk;
	logic arstN;
	logic [wordBits-1:0] imemAddr;
	logic [wordBits-1:0] imemData;
	retireInfo retire;
	logic halted;
	logic illegal;

	logic [wordBits-1:0] imem [imemWords];
	int progPc;
	retireInfo expected [$];
	retireInfo seen [$];
	logic [31:0] lcgState;
	int errors;
	int checks;

	wiscCore #(
		.dmemAddrBits(dmemAddrBits)
	) i_wiscCore (
		.clk(clk),
		.arstN(arstN),
		.imemAddr(imemAddr),
		.imemData(imemData),
		.retire(retire),
		.halted(halted),
		.illegal(illegal)
	);

	bind wiscCore wiscCore_assert i_wiscCoreAssert (
		.clk(clk),
		.arstN(arstN),
		.imemAddr(imemAddr),
		.retire(retire),
		.halted(halted)
	);

	always #5 clk = ~clk;

	// Instruction memory, word indexed
	assign imemData = imem[imemAddr[8:1]];

	// Register writes seen half a cycle before commit
	always @(negedge clk) begin
		if (arstN && retire.wen) begin
			seen.push_back(retire);
		end
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////
	function automatic logic [15:0] rand16();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState[31:16];
	endfunction

	function automatic logic [15:0] encodeR(opcodeT op, int rs, int rt, int rd, functT fn);
		return {op, 3'(rs), 3'(rt), 3'(rd), fn};
	endfunction

	function automatic logic [15:0] encodeI1(opcodeT op, int rs, int rt, logic [4:0] imm);
		return {op, 3'(rs), 3'(rt), imm};
	endfunction

	function automatic logic [15:0] encodeI2(opcodeT op, int rs, logic [7:0] imm);
		return {op, 3'(rs), imm};
	endfunction

	function automatic logic [15:0] encodeJ(opcodeT op, logic [10:0] disp);
		return {op, disp};
	endfunction

	// One bit position per step
	function automatic logic [15:0] rotateLeft(logic [15:0] v, int n);
		logic [15:0] r;
		r = v;
		for (int i = 0; i < n % 16; i++) begin
			r = {r[14:0], r[15]};
		end
		return r;
	endfunction

	function automatic logic [15:0] rotateRight(logic [15:0] v, int n);
		logic [15:0] r;
		r = v;
		for (int i = 0; i < n % 16; i++) begin
			r = {r[0], r[15:1]};
		end
		return r;
	endfunction

	function automatic logic [15:0] reverseBits(logic [15:0] v);
		logic [15:0] r;
		for (int i = 0; i < 16; i++) begin
			r[15-i] = v[i];
		end
		return r;
	endfunction

	task automatic checkEq(input string sig, input logic [15:0] got, input logic [15:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch %s: got %h, expected %h", sig, got, exp);
		end
	endtask

	// Halt words carrying their own word index
	task automatic clearProgram();
		for (int i = 0; i < imemWords; i++) begin
			imem[i] = {opHalt, 11'(i)};
		end
		progPc = 0;
		expected.delete();
	endtask

	task automatic emit(input logic [15:0] word);
		imem[progPc[8:1]] = word;
		progPc += 2;
	endtask

	task automatic expectWrite(input int idx, input logic [15:0] data);
		expected.push_back(retireInfo'{wen: 1'b1, idx: 3'(idx), data: data});
	endtask

	// Marker words, lbi of 5a into r5
	task automatic padTo(input int addr);
		while (progPc < addr) begin
			emit(encodeI2(opLbi, 5, 8'h5a));
		end
	endtask

	// lbi then slbi
	task automatic loadConst(input int r, input logic [15:0] value);
		emit(encodeI2(opLbi, r, value[15:8]));
		expectWrite(r, {{8{value[15]}}, value[15:8]});
		emit(encodeI2(opSlbi, r, value[7:0]));
		expectWrite(r, value);
	endtask

	// R-format on r1 and r2
	task automatic addRegOp(input opcodeT op, input functT fn, input int rd,
			input logic [15:0] value);
		emit(encodeR(op, 1, 2, rd, fn));
		expectWrite(rd, value);
	endtask

	// I-format 1 on r1
	task automatic addImmOp(input opcodeT op, input int rt, input logic [4:0] imm,
			input logic [15:0] value);
		emit(encodeI1(op, 1, rt, imm));
		expectWrite(rt, value);
	endtask

	task automatic applyReset();
		@(posedge clk);
		arstN <= 1'b0;
		seen.delete();
		repeat (4) @(posedge clk);
		arstN <= 1'b1;
	endtask

	// Reset, run to halt, compare the write trace
	task automatic runProgram(input string name);
		int cycles;
		applyReset();
		cycles = 0;
		while (halted !== 1'b1 && cycles < runLimit) begin
			@(negedge clk);
			cycles++;
		end
		if (halted !== 1'b1) begin
			errors++;
			$display("%s program did not halt within %0d cycles", name, runLimit);
		end
		repeat (settleCycles) @(negedge clk);
		@(posedge clk);
		checks++;
		if (seen.size() != expected.size()) begin
			errors++;
			$display("%s program retired %0d register writes, %0d expected",
				name, seen.size(), expected.size());
		end
		for (int i = 0; i < seen.size() && i < expected.size(); i++) begin
			checkEq($sformatf("retire.idx (%s write %0d)", name, i),
				16'(seen[i].idx), 16'(expected[i].idx));
			checkEq($sformatf("retire.data (%s write %0d)", name, i),
				seen[i].data, expected[i].data);
		end
	endtask

	//////////////////////////////
	// Directed tests
	//////////////////////////////
	task automatic resetState();
		clearProgram();
		applyReset();
		@(negedge clk);
		checkEq("imemAddr", imemAddr, 16'h0000);
		checkEq("halted", 16'(halted), 16'h0000);
		checkEq("illegal", 16'(illegal), 16'h0000);
	endtask

	task automatic aluResults();
		logic [15:0] a;
		logic [15:0] b;
		logic [4:0] imm;
		logic [15:0] immS;
		logic [15:0] immZ;
		int s;
		clearProgram();
		a = rand16();
		b = rand16();
		imm = 5'(rand16());
		immS = {{11{imm[4]}}, imm};
		immZ = {11'b0, imm};
		s = b[3:0];
		loadConst(1, a);
		loadConst(2, b);
		// Arithmetic and logic, rt minus rs for sub
		addRegOp(opAlu1, fnAdd, 3, a + b);
		addRegOp(opAlu1, fnSub, 4, b - a);
		addRegOp(opAlu1, fnXor, 5, a ^ b);
		addRegOp(opAlu1, fnAndn, 6, a & ~b);
		// Shifts by rt modulo 16
		addRegOp(opAlu2, fnRol, 3, rotateLeft(a, s));
		addRegOp(opAlu2, fnSll, 4, a << s);
		addRegOp(opAlu2, fnRor, 5, rotateRight(a, s));
		addRegOp(opAlu2, fnSrl, 6, a >> s);
		// Compares, signed except sco
		addRegOp(opSeq, 2'b00, 3, 16'(a == b));
		addRegOp(opSlt, 2'b00, 4, 16'($signed(a) < $signed(b)));
		addRegOp(opSle, 2'b00, 5, 16'($signed(a) <= $signed(b)));
		addRegOp(opSco, 2'b00, 6, 16'((32'(a) + 32'(b)) >> 16));
		emit(encodeR(opSeq, 1, 1, 7, 2'b00));
		expectWrite(7, 16'h0001);
		emit(encodeR(opBtr, 1, 0, 7, 2'b00));
		expectWrite(7, reverseBits(a));
		// I-format 1 into rt
		addImmOp(opAddi, 3, imm, a + immS);
		addImmOp(opSubi, 4, imm, immS - a);
		addImmOp(opAndni, 5, imm, a & ~immZ);
		addImmOp(opXori, 6, imm, a ^ immZ);
		addImmOp(opRoli, 3, imm, rotateLeft(a, imm[3:0]));
		addImmOp(opSlli, 4, imm, a << imm[3:0]);
		addImmOp(opRori, 5, imm, rotateRight(a, imm[3:0]));
		addImmOp(opSrli, 6, imm, a >> imm[3:0]);
		runProgram("alu");
	endtask

	task automatic storeLoad();
		logic [15:0] base;
		logic [15:0] d1;
		logic [15:0] d2;
		clearProgram();
		base = 16'h0080 | (rand16() & 16'h003e);
		d1 = rand16();
		d2 = rand16();
		loadConst(1, base);
		loadConst(2, d1);
		loadConst(6, d2);
		// Store at base plus 4 and read back
		emit(encodeI1(opSt, 1, 2, 5'd4));
		emit(encodeI1(opLd, 1, 3, 5'd4));
		expectWrite(3, d1);
		// stu at base minus 2 moves r1
		emit(encodeI1(opStu, 1, 6, 5'h1e));
		expectWrite(1, base - 16'd2);
		emit(encodeI1(opLd, 1, 5, 5'd0));
		expectWrite(5, d2);
		emit(encodeI1(opLd, 1, 4, 5'd6));
		expectWrite(4, d1);
		runProgram("memory");
	endtask

	task automatic branchSkips();
		opcodeT ops [4] = '{opBnez, opBeqz, opBltz, opBgez};
		logic [7:0] vals [3] = '{8'h00, 8'h05, 8'hfd};
		logic [15:0] v;
		logic taken;
		clearProgram();
		for (int i = 0; i < 4; i++) begin
			for (int j = 0; j < 3; j++) begin
				v = {{8{vals[j][7]}}, vals[j]};
				emit(encodeI2(opLbi, 1, vals[j]));
				expectWrite(1, v);
				case (ops[i])
					opBnez: taken = (v != 16'h0000);
					opBeqz: taken = (v == 16'h0000);
					opBltz: taken = v[15];
					default: taken = !v[15];
				endcase
				// Displacement 2 skips the marker
				emit(encodeI2(ops[i], 1, 8'd2));
				padTo(progPc + 2);
				if (!taken) begin
					expectWrite(5, 16'h005a);
				end
				emit(encodeI2(opLbi, 6, 8'(i * 3 + j)));
				expectWrite(6, 16'(i * 3 + j));
			end
		end
		runProgram("branches");
	endtask

	task automatic jumpRedirects();
		int linkPc;
		clearProgram();
		// j over two markers
		emit(encodeJ(opJ, 11'd4));
		padTo(6);
		linkPc = progPc + 2;
		emit(encodeJ(opJal, 11'd2));
		expectWrite(7, 16'(linkPc));
		padTo(linkPc + 2);
		emit(encodeI2(opLbi, 2, 8'd40));
		expectWrite(2, 16'd40);
		// jr to r2 plus 4
		emit(encodeI2(opJr, 2, 8'd4));
		padTo(44);
		linkPc = progPc + 2;
		// jalr to r2 plus 20
		emit(encodeI2(opJalr, 2, 8'd20));
		expectWrite(7, 16'(linkPc));
		padTo(60);
		emit(encodeI2(opLbi, 3, 8'h33));
		expectWrite(3, 16'h0033);
		runProgram("jumps");
	endtask

	task automatic haltStops();
		logic [4:0] badOps [2] = '{5'b00001, opSiic};
		logic [15:0] v;
		int stopPc;
		v = rand16();
		clearProgram();
		loadConst(1, v);
		stopPc = progPc;
		emit(encodeJ(opHalt, 11'd0));
		// Never reached
		emit(encodeI2(opLbi, 2, 8'h11));
		runProgram("halt");
		checkEq("illegal", 16'(illegal), 16'h0000);
		checkEq("imemAddr", imemAddr, 16'(stopPc));
		for (int k = 0; k < 2; k++) begin
			clearProgram();
			loadConst(1, v);
			stopPc = progPc;
			emit({badOps[k], 11'h000});
			padTo(progPc + 2);
			runProgram($sformatf("illegal %b", badOps[k]));
			checkEq("illegal", 16'(illegal), 16'h0001);
			checkEq("halted", 16'(halted), 16'h0001);
			checkEq("imemAddr", imemAddr, 16'(stopPc));
		end
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////
	initial begin
		int assertFails;
		clk = 1'b0;
		arstN = 1'b0;
		lcgState = 32'h6211a268;
		errors = 0;
		checks = 0;
		clearProgram();
		resetState();
		aluResults();
		storeLoad();
		branchSkips();
		jumpRedirects();
		haltStops();
		assertFails = i_wiscCore.i_wiscCoreAssert.failCount;
		$display("Checks %0d, errors %0d, assertion failures %0d", checks, errors, assertFails);
		if (errors == 0 && assertFails == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// ==== testbench/wiscCore_assert.sv ====
// Halt and retire assertions
module wiscCore_assert import isaPkg::*, ctrlPkg::*; (
	input logic clk,
	input logic arstN,
	input logic [wordBits-1:0] imemAddr,
	input retireInfo retire,
	input logic halted
);

	timeunit 1ns;
	timeprecision 1ps;

	// Number of failed assertions
	int failCount = 0;

	// Fetch address frozen once halted
	pcHeld: assert property (@(posedge clk) disable iff (!arstN)
		halted |=> $stable(imemAddr))
	else begin
		failCount++;
		$error("imemAddr changed while halted");
	end

	// No register write on the halting edge or after it
	noRetireHalted: assert property (@(posedge clk) disable iff (!arstN)
		halted |-> !$past(retire.wen))
	else begin
		failCount++;
		$error("retire.wen high on or after the halting edge");
	end

	// Only reset clears halt
	haltSticky: assert property (@(posedge clk)
		$fell(halted) |-> !arstN)
	else begin
		failCount++;
		$error("halted fell without reset");
	end

endmodule

// ==== verilog/ctrlPkg.sv ====
// Control and trace types
package ctrlPkg;

	import isaPkg::*;

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluXor, aluAndn,
		aluRol, aluSll, aluRor, aluSrl,
		aluSeq, aluSlt, aluSle, aluSco,
		aluBtr, aluPassB, aluSlbi
	} aluOpT;

	typedef enum logic [2:0] {
		brNone, brBnez, brBeqz, brBltz, brBgez
	} branchKindT;

	// Same encoding as RegDst of the old decoder
	typedef enum logic [1:0] {
		dstRd = 2'b00,
		dstRtIform = 2'b01,
		dstRs = 2'b10,
		dstR7 = 2'b11
	} regDstT;

	typedef enum logic [2:0] {
		immZero5, immSign5, immZero8, immSign8, immSign11
	} immSelT;

	//////////////////////////////
	// Decoder output
	//////////////////////////////
	typedef struct packed {
		logic regWrite;
		regDstT regDst;
		immSelT immSel;
		// 1 selects rt, 0 selects the immediate
		logic aluSrc2;
		aluOpT aluOp;
		logic dmemEn;
		logic dmemWrite;
		logic memToReg;
		branchKindT branchKind;
		// Register indirect jump
		logic jump;
		// Displacement jump
		logic pcImm;
		// Save pc+2 to R7
		logic link;
		logic halt;
	} ctrlBundle;

	// Register write trace
	typedef struct packed {
		logic wen;
		logic [regIdxBits-1:0] idx;
		logic [wordBits-1:0] data;
	} retireInfo;

endpackage

// ==== verilog/dataMem.sv ====
// Data memory
module dataMem import isaPkg::*; #(
	parameter int dmemAddrBits = 8
) (
	input logic clk,
	input logic [wordBits-1:0] addr,
	input logic [wordBits-1:0] wdata,
	input logic wen,
	output logic [wordBits-1:0] rdata
);

	logic [wordBits-1:0] mem [2**dmemAddrBits];
	logic [dmemAddrBits-1:0] wordIdx;

	// Byte address, bit 0 ignored
	assign wordIdx = addr[dmemAddrBits:1];

	always_ff @(posedge clk) begin
		if (wen) begin
			mem[wordIdx] <= wdata;
		end
	end

	// Combinational read
	assign rdata = mem[wordIdx];

endmodule

// ==== verilog/execUnit.sv ====
// Execute unit
module execUnit import isaPkg::*, ctrlPkg::*; (
	input instrFields instr,
	input ctrlBundle ctrl,
	input logic [wordBits-1:0] rsData,
	input logic [wordBits-1:0] rtData,
	input logic [wordBits-1:0] pc,
	input logic [wordBits-1:0] dmemRdata,
	output logic [wordBits-1:0] dmemAddr,
	output logic [wordBits-1:0] dmemWdata,
	output logic dmemWen,
	output retireInfo wb,
	output logic redirect,
	output logic [wordBits-1:0] targetPc
);

	logic [4:0] imm5;
	logic [7:0] imm8;
	logic [10:0] imm11;
	logic [wordBits-1:0] imm;
	logic [wordBits-1:0] opA;
	logic [wordBits-1:0] opB;
	logic [wordBits-1:0] aluRes;
	logic [wordBits-1:0] btrRes;
	logic [wordBits-1:0] pcPlus2;
	logic [wordBits:0] addWide;
	logic [2*wordBits-1:0] rolWide;
	logic [2*wordBits-1:0] rorWide;
	logic [$clog2(wordBits)-1:0] shamt;
	logic taken;

	//////////////////////////////
	// Immediate
	//////////////////////////////
	assign imm5 = {instr.rd, instr.funct};
	assign imm8 = {instr.rt, instr.rd, instr.funct};
	assign imm11 = {instr.rs, instr.rt, instr.rd, instr.funct};

	always_comb begin
		case (ctrl.immSel)
			immZero5: imm = {{(wordBits-5){1'b0}}, imm5};
			immSign5: imm = {{(wordBits-5){imm5[4]}}, imm5};
			immZero8: imm = {{(wordBits-8){1'b0}}, imm8};
			immSign8: imm = {{(wordBits-8){imm8[7]}}, imm8};
			immSign11: imm = {{(wordBits-11){imm11[10]}}, imm11};
			default: imm = '0;
		endcase
	end

	//////////////////////////////
	// ALU
	//////////////////////////////
	assign opA = rsData;
	assign opB = ctrl.aluSrc2 ? rtData : imm;
	// Amount modulo the word width
	assign shamt = opB[$clog2(wordBits)-1:0];
	assign addWide = {1'b0, opA} + {1'b0, opB};
	// Rotates through a doubled word
	assign rolWide = {opA, opA} << shamt;
	assign rorWide = {opA, opA} >> shamt;

	always_comb begin
		for (int i = 0; i < wordBits; i++) begin
			btrRes[i] = opA[wordBits-1-i];
		end
	end

	always_comb begin
		case (ctrl.aluOp)
			aluAdd: aluRes = addWide[wordBits-1:0];
			// Subtract is rt minus rs, or imm minus rs
			aluSub: aluRes = opB - opA;
			aluXor: aluRes = opA ^ opB;
			aluAndn: aluRes = opA & ~opB;
			aluRol: aluRes = rolWide[2*wordBits-1:wordBits];
			aluSll: aluRes = opA << shamt;
			aluRor: aluRes = rorWide[wordBits-1:0];
			aluSrl: aluRes = opA >> shamt;
			aluSeq: aluRes = wordBits'(opA == opB);
			aluSlt: aluRes = wordBits'($signed(opA) < $signed(opB));
			aluSle: aluRes = wordBits'($signed(opA) <= $signed(opB));
			// Carry out of rs plus rt
			aluSco: aluRes = wordBits'(addWide[wordBits]);
			aluBtr: aluRes = btrRes;
			// lbi
			aluPassB: aluRes = opB;
			aluSlbi: aluRes = (opA << 8) | opB;
			default: aluRes = '0;
		endcase
	end

	//////////////////////////////
	// Branch and target
	//////////////////////////////
	always_comb begin
		case (ctrl.branchKind)
			brBnez: taken = |rsData;
			brBeqz: taken = ~|rsData;
			brBltz: taken = rsData[wordBits-1];
			brBgez: taken = ~rsData[wordBits-1];
			default: taken = 1'b0;
		endcase
	end

	assign pcPlus2 = pc + wordBits'(2);
	// jr and jalr take rs plus imm from the ALU add
	assign targetPc = ctrl.jump ? aluRes : pcPlus2 + imm;
	assign redirect = ctrl.jump | ctrl.pcImm | taken;

	// Memory address is rs plus imm
	assign dmemAddr = aluRes;
	// Store data from the I-format destination field
	assign dmemWdata = rtData;
	assign dmemWen = ctrl.dmemEn & ctrl.dmemWrite;

	//////////////////////////////
	// Writeback
	//////////////////////////////
	always_comb begin
		wb.wen = ctrl.regWrite;
		case (ctrl.regDst)
			dstRd: wb.idx = instr.rd;
			dstRtIform: wb.idx = instr.rt;
			dstRs: wb.idx = instr.rs;
			default: wb.idx = '1;
		endcase
		if (ctrl.memToReg) begin
			wb.data = dmemRdata;
		end else if (ctrl.link) begin
			wb.data = pcPlus2;
		end else begin
			// stu lands here with the address
			wb.data = aluRes;
		end
	end

endmodule

// ==== verilog/fetchUnit.sv ====
// Program counter and halt
module fetchUnit import isaPkg::*; (
	input logic clk,
	input logic arstN,
	input logic redirect,
	input logic [wordBits-1:0] targetPc,
	input logic haltReq,
	output logic [wordBits-1:0] pc,
	output logic halted
);

	// Halt is sticky until reset
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= '0;
			halted <= 1'b0;
		end else if (!halted) begin
			if (haltReq) begin
				// pc stays on the halting instruction
				halted <= 1'b1;
			end else if (redirect) begin
				pc <= targetPc;
			end else begin
				pc <= pc + wordBits'(2);
			end
		end
	end

endmodule

// ==== verilog/instrDecode.sv ====
// Instruction decoder
module instrDecode import isaPkg::*, ctrlPkg::*; (
	input instrFields instr,
	output ctrlBundle ctrl,
	output logic illegal
);

	always_comb begin
		// Most instructions write a register
		ctrl.regWrite = 1'b1;
		ctrl.regDst = dstRd;
		ctrl.immSel = immSign5;
		// Immediate operand unless R-format
		ctrl.aluSrc2 = 1'b0;
		// Add also forms load/store addresses and jr targets
		ctrl.aluOp = aluAdd;
		ctrl.dmemEn = 1'b0;
		ctrl.dmemWrite = 1'b0;
		ctrl.memToReg = 1'b0;
		ctrl.branchKind = brNone;
		ctrl.jump = 1'b0;
		ctrl.pcImm = 1'b0;
		ctrl.link = 1'b0;
		ctrl.halt = 1'b0;
		illegal = 1'b0;

		case (instr.opcode)
			//////////////////////////////
			// R-format
			//////////////////////////////
			opAlu1: begin
				ctrl.aluSrc2 = 1'b1;
				case (instr.funct)
					fnAdd: ctrl.aluOp = aluAdd;
					fnSub: ctrl.aluOp = aluSub;
					fnXor: ctrl.aluOp = aluXor;
					fnAndn: ctrl.aluOp = aluAndn;
				endcase
			end
			opAlu2: begin
				ctrl.aluSrc2 = 1'b1;
				case (instr.funct)
					fnRol: ctrl.aluOp = aluRol;
					fnSll: ctrl.aluOp = aluSll;
					fnRor: ctrl.aluOp = aluRor;
					fnSrl: ctrl.aluOp = aluSrl;
				endcase
			end
			opSeq, opSlt, opSle, opSco: begin
				ctrl.aluSrc2 = 1'b1;
				// Comparison picked by low opcode bits
				case (instr.opcode[1:0])
					cmpSeq: ctrl.aluOp = aluSeq;
					cmpSlt: ctrl.aluOp = aluSlt;
					cmpSle: ctrl.aluOp = aluSle;
					cmpSco: ctrl.aluOp = aluSco;
				endcase
			end
			// Single operand, reversed into rd
			opBtr: ctrl.aluOp = aluBtr;

			//////////////////////////////
			// I-format 1
			//////////////////////////////
			opSubi, opAddi: begin
				ctrl.regDst = dstRtIform;
				ctrl.aluOp = (instr.opcode == opSubi) ? aluSub : aluAdd;
			end
			opAndni, opXori: begin
				ctrl.regDst = dstRtIform;
				ctrl.immSel = immZero5;
				ctrl.aluOp = (instr.opcode == opXori) ? aluXor : aluAndn;
			end
			opRoli, opSlli, opRori, opSrli: begin
				ctrl.regDst = dstRtIform;
				ctrl.immSel = immZero5;
				// Same order as the opAlu2 funct values
				case (instr.opcode[1:0])
					fnRol: ctrl.aluOp = aluRol;
					fnSll: ctrl.aluOp = aluSll;
					fnRor: ctrl.aluOp = aluRor;
					fnSrl: ctrl.aluOp = aluSrl;
				endcase
			end
			opSt: begin
				ctrl.regWrite = 1'b0;
				ctrl.dmemEn = 1'b1;
				ctrl.dmemWrite = 1'b1;
			end
			opLd: begin
				ctrl.regDst = dstRtIform;
				ctrl.dmemEn = 1'b1;
				ctrl.memToReg = 1'b1;
			end
			// Store and write the address back to rs
			opStu: begin
				ctrl.regDst = dstRs;
				ctrl.dmemEn = 1'b1;
				ctrl.dmemWrite = 1'b1;
			end

			//////////////////////////////
			// I-format 2 and jumps
			//////////////////////////////
			opBnez, opBeqz, opBltz, opBgez: begin
				ctrl.regWrite = 1'b0;
				ctrl.immSel = immSign8;
				case (instr.opcode)
					opBnez: ctrl.branchKind = brBnez;
					opBeqz: ctrl.branchKind = brBeqz;
					opBltz: ctrl.branchKind = brBltz;
					default: ctrl.branchKind = brBgez;
				endcase
			end
			opLbi: begin
				ctrl.regDst = dstRs;
				ctrl.immSel = immSign8;
				ctrl.aluOp = aluPassB;
			end
			opSlbi: begin
				ctrl.regDst = dstRs;
				ctrl.immSel = immZero8;
				ctrl.aluOp = aluSlbi;
			end
			opJr, opJalr: begin
				ctrl.regWrite = (instr.opcode == opJalr);
				ctrl.regDst = dstR7;
				ctrl.immSel = immSign8;
				ctrl.jump = 1'b1;
				ctrl.link = 1'b1;
			end
			opJ, opJal: begin
				ctrl.regWrite = (instr.opcode == opJal);
				ctrl.regDst = dstR7;
				ctrl.immSel = immSign11;
				ctrl.pcImm = 1'b1;
				ctrl.link = 1'b1;
			end

			// Special
			opNop: ctrl.regWrite = 1'b0;
			opHalt: begin
				ctrl.regWrite = 1'b0;
				ctrl.halt = 1'b1;
			end
			// siic and unused encodings
			default: begin
				ctrl.regWrite = 1'b0;
				illegal = 1'b1;
			end
		endcase
	end

endmodule

// ==== verilog/isaPkg.sv ====
// Instruction set definitions
package isaPkg;

	// Data and instruction width
	localparam int wordBits = 16;
	localparam int regIdxBits = 3;
	localparam int numRegs = 1 << regIdxBits;

	//////////////////////////////
	// Opcodes
	//////////////////////////////
	typedef enum logic [4:0] {
		// Special
		opHalt  = 5'b00000,
		opSiic  = 5'b00010,
		opNop   = 5'b00011,
		// Jumps
		opJ     = 5'b00100,
		opJr    = 5'b00101,
		opJal   = 5'b00110,
		opJalr  = 5'b00111,
		// I-format 1 arithmetic
		opSubi  = 5'b01000,
		opAddi  = 5'b01001,
		opAndni = 5'b01010,
		opXori  = 5'b01011,
		// Conditional branches
		opBnez  = 5'b01100,
		opBeqz  = 5'b01101,
		opBltz  = 5'b01110,
		opBgez  = 5'b01111,
		// Memory and byte loads
		opSt    = 5'b10000,
		opLd    = 5'b10001,
		opSlbi  = 5'b10010,
		opStu   = 5'b10011,
		// I-format 1 shifts
		opRoli  = 5'b10100,
		opSlli  = 5'b10101,
		opRori  = 5'b10110,
		opSrli  = 5'b10111,
		opLbi   = 5'b11000,
		opBtr   = 5'b11001,
		// R-format groups selected by funct
		opAlu2  = 5'b11010,
		opAlu1  = 5'b11011,
		// Compare group selected by low opcode bits
		opSeq   = 5'b11100,
		opSlt   = 5'b11101,
		opSle   = 5'b11110,
		opSco   = 5'b11111
	} opcodeT;

	typedef logic [1:0] functT;

	// Funct values of opAlu1
	localparam functT fnAdd = 2'b00;
	localparam functT fnSub = 2'b01;
	localparam functT fnXor = 2'b10;
	localparam functT fnAndn = 2'b11;
	// Funct values of opAlu2
	localparam functT fnRol = 2'b00;
	localparam functT fnSll = 2'b01;
	localparam functT fnRor = 2'b10;
	localparam functT fnSrl = 2'b11;
	// Low opcode bits of the compare group
	localparam logic [1:0] cmpSeq = 2'b00;
	localparam logic [1:0] cmpSlt = 2'b01;
	localparam logic [1:0] cmpSle = 2'b10;
	localparam logic [1:0] cmpSco = 2'b11;

	// One instruction word
	// I-format 1 puts its destination in rt and imm5 in rd and funct
	typedef struct packed {
		opcodeT opcode;
		logic [regIdxBits-1:0] rs;
		logic [regIdxBits-1:0] rt;
		logic [regIdxBits-1:0] rd;
		functT funct;
	} instrFields;

endpackage

// ==== verilog/regFile.sv ====
// Register file
module regFile import isaPkg::*, ctrlPkg::*; (
	input logic clk,
	input logic arstN,
	input logic [regIdxBits-1:0] rsIdx,
	input logic [regIdxBits-1:0] rtIdx,
	output logic [wordBits-1:0] rsData,
	output logic [wordBits-1:0] rtData,
	input retireInfo wr
);

	logic [wordBits-1:0] regs [numRegs];

	// R0 is an ordinary register in this ISA
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < numRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (wr.wen) begin
			regs[wr.idx] <= wr.data;
		end
	end

	// Reads see the old value until the edge
	assign rsData = regs[rsIdx];
	assign rtData = regs[rtIdx];

endmodule

// ==== verilog/wiscCore.sv ====
// Single-cycle core top
module wiscCore import isaPkg::*, ctrlPkg::*; #(
	parameter int dmemAddrBits = 8
) (
	input logic clk,
	input logic arstN,
	output logic [wordBits-1:0] imemAddr,
	input logic [wordBits-1:0] imemData,
	output retireInfo retire,
	output logic halted,
	output logic illegal
);

	instrFields instr;
	ctrlBundle ctrl;
	logic [wordBits-1:0] rsData;
	logic [wordBits-1:0] rtData;
	logic [wordBits-1:0] pc;
	logic [wordBits-1:0] dmemAddr;
	logic [wordBits-1:0] dmemWdata;
	logic [wordBits-1:0] dmemRdata;
	logic dmemWen;
	retireInfo wb;
	logic redirect;
	logic [wordBits-1:0] targetPc;

	assign imemAddr = pc;
	assign instr = instrFields'(imemData);

	// Writes blocked once halted
	always_comb begin
		retire = wb;
		retire.wen = wb.wen & ~halted;
	end

	//////////////////////////////
	// Datapath
	//////////////////////////////
	fetchUnit i_fetchUnit (
		.clk(clk),
		.arstN(arstN),
		.redirect(redirect),
		.targetPc(targetPc),
		.haltReq(ctrl.halt | illegal),
		.pc(pc),
		.halted(halted)
	);

	instrDecode i_instrDecode (
		.instr(instr),
		.ctrl(ctrl),
		.illegal(illegal)
	);

	regFile i_regFile (
		.clk(clk),
		.arstN(arstN),
		.rsIdx(instr.rs),
		.rtIdx(instr.rt),
		.rsData(rsData),
		.rtData(rtData),
		.wr(retire)
	);

	execUnit i_execUnit (
		.instr(instr),
		.ctrl(ctrl),
		.rsData(rsData),
		.rtData(rtData),
		.pc(pc),
		.dmemRdata(dmemRdata),
		.dmemAddr(dmemAddr),
		.dmemWdata(dmemWdata),
		.dmemWen(dmemWen),
		.wb(wb),
		.redirect(redirect),
		.targetPc(targetPc)
	);

	dataMem #(
		.dmemAddrBits(dmemAddrBits)
	) i_dataMem (
		.clk(clk),
		.addr(dmemAddr),
		.wdata(dmemWdata),
		.wen(dmemWen & ~halted),
		.rdata(dmemRdata)
	);

endmodule
